// File: source/upscaler_pkg.sv
`default_nettype none

package upscaler_pkg;

	// colour component width and scaler fraction bits
	localparam int COMPONENT_DEPTH = 8;
	localparam int SCALE_PRECISION = 6;

	typedef struct packed {
		logic [COMPONENT_DEPTH-1:0] red;
		logic [COMPONENT_DEPTH-1:0] green;
		logic [COMPONENT_DEPTH-1:0] blue;
	} pixel_t;

	// lock progress of a timing meter
	typedef enum logic [1:0] {
		SEEK        = 2'd0,
		FIRST_FRAME = 2'd1,
		LOCKED      = 2'd2
	} meter_state_e;

	// source positions advanced per destination pixel, in fixed point
	function automatic int unsigned scale_factor(input int unsigned src_size,
	                                             input int unsigned dst_size);
		int unsigned step;
		if (dst_size == 0) begin
			step = 0;
		end else begin
			step = (src_size << SCALE_PRECISION) / dst_size;
		end
		return step;
	endfunction

endpackage

`default_nettype wire

// File: source/line_buffer_if.sv
`default_nettype none

interface line_buffer_if #(
	parameter int LINE_BUFFER_SIZE = 64,
	parameter int LINE_BUFFER_COUNT = 16
) ();
	localparam int COL_W = $clog2(LINE_BUFFER_SIZE);
	localparam int LINE_W = $clog2(LINE_BUFFER_COUNT);

	// write side, fed by the input raster
	logic wr_en;
	logic [LINE_W-1:0] wr_line;
	logic [COL_W-1:0] wr_col;
	upscaler_pkg::pixel_t wr_pixel;

	// read side, addressed by the scaler
	logic rd_en;
	logic [LINE_W-1:0] rd_line;
	logic [COL_W-1:0] rd_col;
	upscaler_pkg::pixel_t rd_pixel;

	// ring line holding the first line of the newest input frame
	logic [LINE_W-1:0] sof_line;

	modport writer (output wr_en, wr_line, wr_col, wr_pixel, sof_line);
	modport reader (output rd_en, rd_line, rd_col, input rd_pixel, sof_line);
	modport ram (input wr_en, wr_line, wr_col, wr_pixel, rd_en, rd_line, rd_col,
		output rd_pixel);
endinterface

`default_nettype wire

// File: source/frame_timing_meter.sv
`default_nettype none

module frame_timing_meter #(
	parameter int COUNTER_DEPTH = 12
) (
	input  logic                     i_ClkB,
	input  logic                     i_rst,
	input  logic                     i_advance,
	input  logic                     i_hsync,
	input  logic                     i_vsync,
	input  logic                     i_hblank,
	input  logic                     i_vblank,
	output logic                     o_locked,
	output logic [COUNTER_DEPTH-1:0] o_width,
	output logic [COUNTER_DEPTH-1:0] o_height
);
	upscaler_pkg::meter_state_e state_q;
	logic hsync_q;
	logic vsync_q;
	logic [COUNTER_DEPTH-1:0] pix_count_q;
	logic [COUNTER_DEPTH-1:0] line_count_q;
	logic [COUNTER_DEPTH-1:0] last_width_q;
	logic line_active_q;
	logic line_start;
	logic frame_start;
	logic active_pixel;
	logic [COUNTER_DEPTH-1:0] width_now;
	logic [COUNTER_DEPTH-1:0] height_now;

	// syncs are active low, edges taken against the last advanced level
	assign line_start = i_advance && !i_hsync && hsync_q;
	assign frame_start = i_advance && !i_vsync && vsync_q;
	assign active_pixel = i_advance && !i_hblank && !i_vblank;

	// width of the latest line that carried pixels, blank lines are skipped
	assign width_now = (line_start && pix_count_q != '0) ? pix_count_q : last_width_q;
	// a line still open at a frame start counts if it had pixels
	assign height_now = line_count_q + COUNTER_DEPTH'(line_active_q);

	assign o_locked = (state_q == upscaler_pkg::LOCKED);

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			state_q <= upscaler_pkg::SEEK;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			pix_count_q <= '0;
			line_count_q <= '0;
			last_width_q <= '0;
			line_active_q <= 1'b0;
			o_width <= '0;
			o_height <= '0;
		end else begin
			if (i_advance) begin
				hsync_q <= i_hsync;
				vsync_q <= i_vsync;
			end

			if (line_start) begin
				pix_count_q <= COUNTER_DEPTH'(active_pixel);
				last_width_q <= width_now;
			end else if (active_pixel) begin
				pix_count_q <= pix_count_q + 1'b1;
			end

			if (frame_start) begin
				line_count_q <= '0;
			end else if (line_start) begin
				line_count_q <= height_now;
			end

			if (line_start || frame_start) begin
				line_active_q <= active_pixel;
			end else if (active_pixel) begin
				line_active_q <= 1'b1;
			end

			// sizes are captured once, on entering lock
			if (frame_start) begin
				case (state_q)
					upscaler_pkg::SEEK: state_q <= upscaler_pkg::FIRST_FRAME;
					upscaler_pkg::FIRST_FRAME: begin
						state_q <= upscaler_pkg::LOCKED;
						o_width <= width_now;
						o_height <= height_now;
					end
					default: state_q <= state_q;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/line_writer.sv
`default_nettype none

module line_writer #(
	parameter int LINE_BUFFER_SIZE = 64,
	parameter int LINE_BUFFER_COUNT = 16
) (
	input  logic                 i_ClkB,
	input  logic                 i_rst,
	input  logic                 i_pix_en,
	input  logic                 i_hsync,
	input  logic                 i_vsync,
	input  logic                 i_hblank,
	input  logic                 i_vblank,
	input  upscaler_pkg::pixel_t i_pixel,
	line_buffer_if.writer        lb
);
	localparam int COL_W = $clog2(LINE_BUFFER_SIZE);
	localparam int LINE_W = $clog2(LINE_BUFFER_COUNT);

	logic hsync_q;
	logic vsync_q;
	logic [COL_W-1:0] col_q;
	logic [LINE_W-1:0] line_q;
	logic written_q;
	logic framed_q;
	logic line_start;
	logic frame_start;
	logic accept;
	logic [COL_W-1:0] cur_col;
	logic [LINE_W-1:0] next_line;
	logic [LINE_W-1:0] cur_line;

	assign line_start = i_pix_en && !i_hsync && hsync_q;
	assign frame_start = i_pix_en && !i_vsync && vsync_q;

	// nothing is stored until the first frame start marks a ring line
	assign accept = i_pix_en && !i_hblank && !i_vblank && framed_q;

	assign next_line = (line_q == LINE_W'(LINE_BUFFER_COUNT - 1)) ? '0 : line_q + 1'b1;
	// blank lines do not take a slot in the ring
	assign cur_line = (line_start && written_q) ? next_line : line_q;
	assign cur_col = line_start ? '0 : col_q;

	// write goes out in the cycle the pixel is accepted
	assign lb.wr_en = accept;
	assign lb.wr_line = cur_line;
	assign lb.wr_col = cur_col;
	assign lb.wr_pixel = i_pixel;

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			col_q <= '0;
			line_q <= '0;
			written_q <= 1'b0;
			framed_q <= 1'b0;
			lb.sof_line <= '0;
		end else begin
			if (i_pix_en) begin
				hsync_q <= i_hsync;
				vsync_q <= i_vsync;
			end
			line_q <= cur_line;
			// overlong lines wrap around the buffer
			if (accept) begin
				col_q <= (cur_col == COL_W'(LINE_BUFFER_SIZE - 1)) ? '0 : cur_col + 1'b1;
			end else begin
				col_q <= cur_col;
			end
			if (line_start) begin
				written_q <= accept;
			end else if (accept) begin
				written_q <= 1'b1;
			end
			if (frame_start) begin
				framed_q <= 1'b1;
				lb.sof_line <= cur_line;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/line_buffer_ram.sv
`default_nettype none

module line_buffer_ram #(
	parameter int LINE_BUFFER_SIZE = 64,
	parameter int LINE_BUFFER_COUNT = 16
) (
	input logic        i_ClkB,
	line_buffer_if.ram lb
);
	// one RGB word per column, one row per ring line
	upscaler_pkg::pixel_t mem [LINE_BUFFER_COUNT][LINE_BUFFER_SIZE];

	always_ff @(posedge i_ClkB) begin
		if (lb.wr_en) begin
			mem[lb.wr_line][lb.wr_col] <= lb.wr_pixel;
		end
	end

	// registered read, data one cycle after the address
	// same address in the same cycle returns the old word
	always_ff @(posedge i_ClkB) begin
		if (lb.rd_en) begin
			lb.rd_pixel <= mem[lb.rd_line][lb.rd_col];
		end
	end

endmodule

`default_nettype wire

// File: source/line_reader_scaler.sv
`default_nettype none

module line_reader_scaler #(
	parameter int LINE_BUFFER_SIZE = 64,
	parameter int LINE_BUFFER_COUNT = 16,
	parameter int COUNTER_DEPTH = 12,
	parameter int VERTICAL_SYNC_DELAY = 2
) (
	input  logic                     i_ClkB,
	input  logic                     i_rst,
	input  logic                     i_hsync,
	input  logic                     i_vsync,
	input  logic                     i_hblank,
	input  logic                     i_vblank,
	input  logic                     i_locked_a,
	input  logic                     i_locked_b,
	input  logic [COUNTER_DEPTH-1:0] i_src_width,
	input  logic [COUNTER_DEPTH-1:0] i_src_height,
	input  logic [COUNTER_DEPTH-1:0] i_dst_width,
	input  logic [COUNTER_DEPTH-1:0] i_dst_height,
	line_buffer_if.reader            lb,
	output logic                     o_hsync,
	output logic                     o_vsync,
	output logic                     o_hblank,
	output logic                     o_vblank,
	output upscaler_pkg::pixel_t     o_pixel
);
	localparam int COL_W = $clog2(LINE_BUFFER_SIZE);
	localparam int LINE_W = $clog2(LINE_BUFFER_COUNT);
	localparam int FRAC = upscaler_pkg::SCALE_PRECISION;
	localparam int ACC_W = COUNTER_DEPTH + FRAC;
	localparam int DLY = VERTICAL_SYNC_DELAY;

	logic hsync_q;
	logic [DLY-1:0] vsync_sr_q;
	logic [DLY-1:0] vblank_sr_q;
	logic vsync_line_q;
	logic vblank_line_q;
	logic line_start;
	logic frame_start;
	logic dly_vsync;
	logic dly_vblank;
	logic active;
	logic [ACC_W-1:0] hstep_q;
	logic [ACC_W-1:0] vstep_q;
	logic [ACC_W-1:0] hacc_q;
	logic [ACC_W-1:0] vacc_q;
	logic [ACC_W-1:0] hacc_cur;
	logic [ACC_W-1:0] vacc_cur;
	logic [LINE_W-1:0] sof_q;
	logic [LINE_W-1:0] sof_cur;
	logic [COUNTER_DEPTH:0] line_sum;
	logic [1:0] hsync_p;
	logic [1:0] vsync_p;
	logic [1:0] hblank_p;
	logic [1:0] vblank_p;

	assign line_start = !i_hsync && hsync_q;

	// delayed levels switch exactly at a line start and hold for the line
	assign dly_vsync = line_start ? vsync_sr_q[DLY-1] : vsync_line_q;
	assign dly_vblank = line_start ? vblank_sr_q[DLY-1] : vblank_line_q;
	assign frame_start = line_start && !vsync_sr_q[DLY-1] && vsync_line_q;
	assign active = !i_hblank && !dly_vblank;

	// accumulators restart at their own boundary
	assign hacc_cur = line_start ? '0 : hacc_q;
	assign vacc_cur = frame_start ? '0 : vacc_q;
	assign sof_cur = frame_start ? lb.sof_line : sof_q;
	assign line_sum = (COUNTER_DEPTH + 1)'(sof_cur) +
		(COUNTER_DEPTH + 1)'(vacc_cur[ACC_W-1:FRAC]);

	// two pipe stages match the address register plus the RAM read
	assign o_hsync = hsync_p[1];
	assign o_vsync = vsync_p[1];
	assign o_hblank = hblank_p[1];
	assign o_vblank = vblank_p[1];
	assign o_pixel = (!o_hblank && !o_vblank && i_locked_b) ? lb.rd_pixel : '0;

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hsync_q <= 1'b1;
			vsync_sr_q <= '1;
			vblank_sr_q <= '0;
			vsync_line_q <= 1'b1;
			vblank_line_q <= 1'b0;
			hstep_q <= '0;
			vstep_q <= '0;
			hacc_q <= '0;
			vacc_q <= '0;
			sof_q <= '0;
			lb.rd_en <= 1'b0;
			lb.rd_line <= '0;
			lb.rd_col <= '0;
			hsync_p <= '1;
			vsync_p <= '1;
			hblank_p <= '0;
			vblank_p <= '0;
		end else begin
			hsync_q <= i_hsync;
			if (line_start) begin
				vsync_sr_q <= DLY'({vsync_sr_q, i_vsync});
				vblank_sr_q <= DLY'({vblank_sr_q, i_vblank});
				vsync_line_q <= vsync_sr_q[DLY-1];
				vblank_line_q <= vblank_sr_q[DLY-1];
				if (i_locked_a) begin
					hstep_q <= ACC_W'(upscaler_pkg::scale_factor(i_src_width, i_dst_width));
				end
			end
			if (i_locked_a && i_locked_b) begin
				vstep_q <= ACC_W'(upscaler_pkg::scale_factor(i_src_height, i_dst_height));
			end

			sof_q <= sof_cur;
			hacc_q <= active ? hacc_cur + hstep_q : hacc_cur;
			// source line picked once per active output line
			if (line_start && !dly_vblank) begin
				lb.rd_line <= LINE_W'(line_sum % LINE_BUFFER_COUNT);
				vacc_q <= vacc_cur + vstep_q;
			end else begin
				vacc_q <= vacc_cur;
			end
			lb.rd_en <= active;
			lb.rd_col <= COL_W'(hacc_cur[ACC_W-1:FRAC] % LINE_BUFFER_SIZE);

			hsync_p <= {hsync_p[0], i_hsync};
			vsync_p <= {vsync_p[0], dly_vsync};
			hblank_p <= {hblank_p[0], i_hblank};
			vblank_p <= {vblank_p[0], dly_vblank};
		end
	end

endmodule

`default_nettype wire

// File: source/upscaler_top.sv
`default_nettype none

module upscaler_top #(
	parameter int LINE_BUFFER_SIZE = 64,
	parameter int LINE_BUFFER_COUNT = 16,
	parameter int COUNTER_DEPTH = 12,
	parameter int VERTICAL_SYNC_DELAY = 2
) (
	input  logic                                   i_ClkB,
	input  logic                                   i_rst,
	// input raster
	input  logic                                   i_pix_en,
	input  logic                                   i_hsync_a,
	input  logic                                   i_vsync_a,
	input  logic                                   i_hblank_a,
	input  logic                                   i_vblank_a,
	input  logic [upscaler_pkg::COMPONENT_DEPTH-1:0] i_red_a,
	input  logic [upscaler_pkg::COMPONENT_DEPTH-1:0] i_green_a,
	input  logic [upscaler_pkg::COMPONENT_DEPTH-1:0] i_blue_a,
	// output reference timing
	input  logic                                   i_hsync_b,
	input  logic                                   i_vsync_b,
	input  logic                                   i_hblank_b,
	input  logic                                   i_vblank_b,
	// lock status and measured sizes
	output logic                                   o_locked_a,
	output logic [COUNTER_DEPTH-1:0]               o_width_a,
	output logic [COUNTER_DEPTH-1:0]               o_height_a,
	output logic                                   o_locked_b,
	output logic [COUNTER_DEPTH-1:0]               o_width_b,
	output logic [COUNTER_DEPTH-1:0]               o_height_b,
	// scaled output raster
	output logic                                   o_hsync_b,
	output logic                                   o_vsync_b,
	output logic                                   o_hblank_b,
	output logic                                   o_vblank_b,
	output logic [upscaler_pkg::COMPONENT_DEPTH-1:0] o_red_b,
	output logic [upscaler_pkg::COMPONENT_DEPTH-1:0] o_green_b,
	output logic [upscaler_pkg::COMPONENT_DEPTH-1:0] o_blue_b
);
	upscaler_pkg::pixel_t pixel_a;
	upscaler_pkg::pixel_t pixel_b;

	line_buffer_if #(
		.LINE_BUFFER_SIZE (LINE_BUFFER_SIZE),
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT)
	) lb ();

	assign pixel_a = '{red: i_red_a, green: i_green_a, blue: i_blue_a};
	assign o_red_b = pixel_b.red;
	assign o_green_b = pixel_b.green;
	assign o_blue_b = pixel_b.blue;

	// input side only moves on enabled pixels
	frame_timing_meter #(.COUNTER_DEPTH(COUNTER_DEPTH)) meter_a (
		.i_ClkB(i_ClkB), .i_rst(i_rst), .i_advance(i_pix_en),
		.i_hsync(i_hsync_a), .i_vsync(i_vsync_a), .i_hblank(i_hblank_a), .i_vblank(i_vblank_a),
		.o_locked(o_locked_a), .o_width(o_width_a), .o_height(o_height_a)
	);

	frame_timing_meter #(.COUNTER_DEPTH(COUNTER_DEPTH)) meter_b (
		.i_ClkB(i_ClkB), .i_rst(i_rst), .i_advance(1'b1),
		.i_hsync(i_hsync_b), .i_vsync(i_vsync_b), .i_hblank(i_hblank_b), .i_vblank(i_vblank_b),
		.o_locked(o_locked_b), .o_width(o_width_b), .o_height(o_height_b)
	);

	line_writer #(
		.LINE_BUFFER_SIZE (LINE_BUFFER_SIZE),
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT)
	) line_writer_i (
		.i_ClkB(i_ClkB), .i_rst(i_rst), .i_pix_en(i_pix_en),
		.i_hsync(i_hsync_a), .i_vsync(i_vsync_a), .i_hblank(i_hblank_a), .i_vblank(i_vblank_a),
		.i_pixel(pixel_a), .lb(lb.writer)
	);

	line_buffer_ram #(
		.LINE_BUFFER_SIZE (LINE_BUFFER_SIZE),
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT)
	) line_buffer_ram_i (
		.i_ClkB(i_ClkB), .lb(lb.ram)
	);

	line_reader_scaler #(
		.LINE_BUFFER_SIZE   (LINE_BUFFER_SIZE),
		.LINE_BUFFER_COUNT  (LINE_BUFFER_COUNT),
		.COUNTER_DEPTH      (COUNTER_DEPTH),
		.VERTICAL_SYNC_DELAY(VERTICAL_SYNC_DELAY)
	) line_reader_scaler_i (
		.i_ClkB(i_ClkB), .i_rst(i_rst),
		.i_hsync(i_hsync_b), .i_vsync(i_vsync_b), .i_hblank(i_hblank_b), .i_vblank(i_vblank_b),
		.i_locked_a(o_locked_a), .i_locked_b(o_locked_b),
		.i_src_width(o_width_a), .i_src_height(o_height_a),
		.i_dst_width(o_width_b), .i_dst_height(o_height_b),
		.lb(lb.reader),
		.o_hsync(o_hsync_b), .o_vsync(o_vsync_b), .o_hblank(o_hblank_b), .o_vblank(o_vblank_b),
		.o_pixel(pixel_b)
	);

endmodule

`default_nettype wire

// File: verification/upscaler_properties.sv
`default_nettype none

module upscaler_properties (
	input logic       i_ClkB,
	input logic       i_rst,
	input logic       i_hsync_b,
	input logic       o_hsync_b,
	input logic       o_hblank_b,
	input logic [7:0] o_red_b,
	input logic [7:0] o_green_b,
	input logic [7:0] o_blue_b,
	input logic       o_locked_a,
	input logic       o_locked_b
);
	timeunit 1ns;
	timeprecision 1ps;

	// output hsync is the reference hsync two cycles late
	hsync_delay_a: assert property (@(posedge i_ClkB) disable iff (i_rst)
		o_hsync_b == $past(i_hsync_b, 2))
		else $error("o_hsync_b is not i_hsync_b delayed by two cycles");

	// no colour leaks into horizontal blanking
	blank_black_a: assert property (@(posedge i_ClkB) disable iff (i_rst)
		o_hblank_b |-> ({o_red_b, o_green_b, o_blue_b} == 24'h0))
		else $error("output pixel is not zero during horizontal blanking");

	// locks only drop on reset
	lock_a_hold_a: assert property (@(posedge i_ClkB) disable iff (i_rst)
		o_locked_a |=> o_locked_a)
		else $error("input lock dropped without reset");

	lock_b_hold_a: assert property (@(posedge i_ClkB) disable iff (i_rst)
		o_locked_b |=> o_locked_b)
		else $error("output lock dropped without reset");

endmodule

bind upscaler_top upscaler_properties upscaler_properties_i (.*);

`default_nettype wire

// File: verification/upscaler_tb.sv
`default_nettype none

module upscaler_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROWS = 4;
	localparam int COLS = 10;
	localparam int FRAC = 6;
	localparam int SEED = 32'h80f54e0f;

	// in w, in h, in hblank, in vblank, out w, out h, out hblank, out vblank,
	// pixel-enable period and frames checked
	// both rasters have the same frame length
	int stim_table [ROWS][COLS] = '{
		'{16, 8,  8, 2, 16,  8,  8, 2, 1, 2},
		'{16, 8, 80, 1, 32, 16, 16, 2, 1, 2},
		'{16, 8, 64, 1, 24, 12, 16, 6, 1, 2},
		'{20, 10, 36, 1, 40, 20, 16, 2, 2, 2}
	};

	logic i_ClkB, i_rst, i_pix_en;
	logic i_hsync_a, i_vsync_a, i_hblank_a, i_vblank_a;
	logic [7:0] i_red_a, i_green_a, i_blue_a;
	logic i_hsync_b, i_vsync_b, i_hblank_b, i_vblank_b;
	logic o_locked_a, o_locked_b;
	logic [11:0] o_width_a, o_height_a, o_width_b, o_height_b;
	logic o_hsync_b, o_vsync_b, o_hblank_b, o_vblank_b;
	logic [7:0] o_red_b, o_green_b, o_blue_b;

	int wi, hi, hbi, vbi, wo, ho, hbo, vbo, pen, nfr, hstep, vstep;
	logic use_rand, running, armed;
	int in_col, in_line, in_phase, in_pick, in_frames;
	int out_col, out_line, out_frames;
	int hist_line [3];
	int hist_col [3];
	logic hist_ok [3];
	int value_errors, other_errors, pix_checked, cycles, limit;

	upscaler_top upscaler_top_i (.*);

	initial begin
		i_ClkB = 1'b0;
		forever #4 i_ClkB = ~i_ClkB;
	end

	function automatic logic [23:0] src_pattern(input int line, input int col);
		logic [7:0] r, g, b;
		r = 8'(col);
		g = 8'(line);
		b = 8'(col ^ (line * 8) ^ 32'h5a);
		return {r, g, b};
	endfunction

	// step in source units per destination unit with six fraction bits
	function automatic int fixed_step(input int src, input int dst);
		if (dst == 0) begin
			return 0;
		end
		return (src * (1 << FRAC)) / dst;
	endfunction

	task automatic log_mismatch(input string msg);
		value_errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	// compares outputs against the output position driven three edges ago
	task automatic check_outputs();
		logic exp_hs, exp_vs, exp_hb, exp_vb;
		logic [23:0] exp_pix, got_pix;
		int dl, x, y;
		got_pix = {o_red_b, o_green_b, o_blue_b};
		exp_hs = 1'b1;
		exp_vs = 1'b1;
		exp_hb = 1'b0;
		exp_vb = 1'b0;
		dl = -1;
		if (hist_ok[2]) begin
			// vertical timing runs two lines behind the reference
			dl = (hist_line[2] + ho + vbo - 2) % (ho + vbo);
			exp_hs = (hist_col[2] >= 2);
			exp_hb = (hist_col[2] < hbo);
			exp_vs = (dl >= 2);
			exp_vb = (dl < vbo);
		end
		if (o_hsync_b !== exp_hs || o_hblank_b !== exp_hb) begin
			log_mismatch($sformatf("hsync/hblank %b%b, expected %b%b",
				o_hsync_b, o_hblank_b, exp_hs, exp_hb));
		end
		if (o_vsync_b !== exp_vs || o_vblank_b !== exp_vb) begin
			log_mismatch($sformatf("vsync/vblank %b%b, expected %b%b",
				o_vsync_b, o_vblank_b, exp_vs, exp_vb));
		end
		if ((exp_hb || exp_vb || !o_locked_b) && got_pix !== 24'h0) begin
			log_mismatch($sformatf("pixel %h in blanking or before lock", got_pix));
		end
		if ((o_locked_a && in_frames < 2) ||
			(o_locked_b && (out_frames < 2 || in_frames < 2))) begin
			other_errors++;
			$display("lock rose before two frames had started");
		end
		if (hist_ok[2] && dl == 0 && hist_col[2] == 0 && o_locked_a && o_locked_b) begin
			armed = 1'b1;
		end
		if (armed && !exp_hb && !exp_vb) begin
			x = hist_col[2] - hbo;
			y = dl - vbo;
			exp_pix = src_pattern((y * vstep) >> FRAC, (x * hstep) >> FRAC);
			pix_checked++;
			if (got_pix !== exp_pix) begin
				log_mismatch($sformatf("pixel x=%0d y=%0d is %h, expected %h",
					x, y, got_pix, exp_pix));
			end
		end
	endtask

	task automatic drive_output_raster();
		for (int i = 2; i > 0; i--) begin
			hist_line[i] = hist_line[i-1];
			hist_col[i] = hist_col[i-1];
			hist_ok[i] = hist_ok[i-1];
		end
		hist_line[0] = out_line;
		hist_col[0] = out_col;
		hist_ok[0] = 1'b1;
		i_hsync_b <= (out_col >= 2);
		i_hblank_b <= (out_col < hbo);
		i_vsync_b <= (out_line >= 2);
		i_vblank_b <= (out_line < vbo);
		if (out_col == 0 && out_line == 0) begin
			out_frames++;
		end
		out_col++;
		if (out_col == wo + hbo) begin
			out_col = 0;
			out_line = (out_line + 1) % (ho + vbo);
		end
	endtask

	task automatic drive_input_raster();
		logic en;
		// random rows move the enabled cycle around inside each slot
		if (use_rand && in_phase == 0) begin
			in_pick = int'($urandom % pen);
		end
		en = (in_phase == in_pick);
		in_phase = (in_phase + 1) % pen;
		i_pix_en <= en;
		if (en) begin
			i_hsync_a <= (in_col >= 2);
			i_hblank_a <= (in_col < hbi);
			i_vsync_a <= (in_line >= 2);
			i_vblank_a <= (in_line < vbi);
			if (in_col >= hbi && in_line >= vbi) begin
				{i_red_a, i_green_a, i_blue_a} <= src_pattern(in_line - vbi, in_col - hbi);
			end else begin
				{i_red_a, i_green_a, i_blue_a} <= 24'h0;
			end
			if (in_col == 0 && in_line == 0) begin
				in_frames++;
			end
			in_col++;
			if (in_col == wi + hbi) begin
				in_col = 0;
				in_line = (in_line + 1) % (hi + vbi);
			end
		end
	endtask

	always @(posedge i_ClkB) begin
		if (!running) begin
			i_pix_en <= 1'b0;
			{i_hsync_a, i_vsync_a, i_hblank_a, i_vblank_a} <= 4'b1100;
			{i_red_a, i_green_a, i_blue_a} <= 24'h0;
			{i_hsync_b, i_vsync_b, i_hblank_b, i_vblank_b} <= 4'b1100;
			in_col = 0;
			in_line = 0;
			in_phase = 0;
			in_pick = 0;
			in_frames = 0;
			out_col = 0;
			out_line = 0;
			out_frames = 0;
			hist_ok = '{1'b0, 1'b0, 1'b0};
			armed = 1'b0;
		end else begin
			check_outputs();
			drive_output_raster();
			drive_input_raster();
		end
	end

	// run limit
	always @(posedge i_ClkB) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run exceeded %0d cycles", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		int row_pixels;
		i_rst = 1'b1;
		i_pix_en = 1'b0;
		{i_hsync_a, i_vsync_a, i_hblank_a, i_vblank_a} = 4'b1100;
		{i_red_a, i_green_a, i_blue_a} = 24'h0;
		{i_hsync_b, i_vsync_b, i_hblank_b, i_vblank_b} = 4'b1100;
		running = 1'b0;
		value_errors = 0;
		other_errors = 0;
		pix_checked = 0;
		cycles = 0;
		void'($urandom(SEED));
		limit = 0;
		for (int r = 0; r < ROWS; r++) begin
			limit += (stim_table[r][9] + 3) * (stim_table[r][4] + stim_table[r][6]) *
				(stim_table[r][5] + stim_table[r][7]) + 12;
		end
		limit = limit * 3 / 2;

		for (int r = 0; r < ROWS; r++) begin
			@(posedge i_ClkB);
			i_rst <= 1'b1;
			running <= 1'b0;
			@(negedge i_ClkB);
			wi = stim_table[r][0];
			hi = stim_table[r][1];
			hbi = stim_table[r][2];
			vbi = stim_table[r][3];
			wo = stim_table[r][4];
			ho = stim_table[r][5];
			hbo = stim_table[r][6];
			vbo = stim_table[r][7];
			pen = stim_table[r][8];
			nfr = stim_table[r][9];
			use_rand = (r == ROWS - 1);
			hstep = fixed_step(wi, wo);
			vstep = fixed_step(hi, ho);
			row_pixels = pix_checked;
			repeat (8) @(posedge i_ClkB);
			i_rst <= 1'b0;
			running <= 1'b1;
			while (out_frames < nfr + 3) @(negedge i_ClkB);

			if (!o_locked_a || int'(o_width_a) != wi || int'(o_height_a) != hi) begin
				log_mismatch($sformatf("row %0d input lock %b size %0dx%0d, expected %0dx%0d",
					r, o_locked_a, o_width_a, o_height_a, wi, hi));
			end
			if (!o_locked_b || int'(o_width_b) != wo || int'(o_height_b) != ho) begin
				log_mismatch($sformatf("row %0d output lock %b size %0dx%0d, expected %0dx%0d",
					r, o_locked_b, o_width_b, o_height_b, wo, ho));
			end
			if (pix_checked == row_pixels) begin
				other_errors++;
				$display("row %0d never reached a checked output frame", r);
			end
		end

		$display("errors: %0d value, %0d other, %0d pixels checked",
			value_errors, other_errors, pix_checked);
		if (value_errors + other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
source/upscaler_pkg.sv
source/line_buffer_if.sv
source/frame_timing_meter.sv
source/line_writer.sv
source/line_buffer_ram.sv
source/line_reader_scaler.sv
source/upscaler_top.sv
verification/upscaler_properties.sv
verification/upscaler_tb.sv

// File: Makefile
# Verilator build and run for the upscaler testbench

TOP := upscaler_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
